// File: source/m1_div_pkg.sv
/* Shared widths, structs and state encoding for the M1 integer divider.
   Imported by every divider module and by the testbench. */
`default_nettype none

package m1_div_pkg;

  // Operand and result width
  localparam int div_width_lp      = 32;
  // One quotient bit per step
  localparam int div_steps_lp      = div_width_lp;
  // Must hold div_steps_lp
  localparam int step_cnt_width_lp = 6;

  // Request from the core, held stable until ack matches req
  typedef struct packed {
    logic [div_width_lp-1:0] dividend;
    logic [div_width_lp-1:0] divisor;
    logic                    is_signed;  // Treat both operands as two's complement
  } div_operands_t;

  // Unsigned view of the operands plus the result sign
  typedef struct packed {
    logic [div_width_lp-1:0] dividend_mag;
    logic [div_width_lp-1:0] divisor_mag;
    logic                    negate;     // Flip both quotient and remainder
  } div_magnitudes_t;

  // Final outputs, updated only on completion
  typedef struct packed {
    logic [div_width_lp-1:0] quotient;
    logic [div_width_lp-1:0] remainder;
  } div_results_t;

  // Control sequence of one division
  typedef enum logic [1:0] {
    st_idle   = 2'd0,  // Waiting for a request toggle
    st_load   = 2'd1,  // Capture operands, preset counter
    st_run    = 2'd2,  // Shift-subtract steps
    st_finish = 2'd3   // Sign fix and ack
  } div_state_t;

endpackage

`default_nettype wire

// File: source/m1_div_ctrl.sv
/* Divider control FSM: detects a new ABP request level, sequences load, run and
   finish, and returns the acknowledge level once the results are registered. */
`timescale 1ns/10ps
`default_nettype none

module m1_div_ctrl import m1_div_pkg::*; (
  input  wire  sys_clock_i,  // System clock
  input  wire  sys_reset_i,  // Sync reset, active high
  input  logic abp_req_i,    // ABP request level
  input  logic last_step_i,  // Counter at final step
  output logic load_o,       // Capture operands
  output logic step_o,       // One iteration
  output logic finish_o,     // Register results
  output logic abp_ack_o     // ABP acknowledge level
);

  div_state_t state_q;     // Current state
  div_state_t state_d;     // Next state
  logic       abp_last_q;  // Last accepted request level

  // Next-state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (abp_req_i != abp_last_q) state_d = st_load;  // Toggle seen
      st_load:   state_d = st_run;
      st_run:    if (last_step_i) state_d = st_finish;            // 32nd step done
      st_finish: state_d = st_idle;
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      state_q    <= st_idle;
      abp_last_q <= 1'b0;
      abp_ack_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == st_idle && abp_req_i != abp_last_q) begin
        abp_last_q <= abp_req_i;  // Accept new level
      end
      if (state_q == st_finish) begin
        abp_ack_o <= abp_last_q;  // Results valid from this edge on
      end
    end
  end

  // State decode
  assign load_o   = (state_q == st_load);
  assign step_o   = (state_q == st_run);
  assign finish_o = (state_q == st_finish);

  // Counter's final step only ever lines up with the run state
  assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    last_step_i |-> step_o)
    else $error("last_step_i high outside the run state");

  // Requester holds its level while a division is in flight
  assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    (state_q != st_idle) |-> $stable(abp_req_i))
    else $error("abp_req_i toggled while the divider was busy");

endmodule

`default_nettype wire

// File: source/m1_div_step_counter.sv
/* Counts the remaining shift-subtract steps of one division.
   Preset on load, decremented per step, flags the last step to the FSM. */
`timescale 1ns/10ps
`default_nettype none

module m1_div_step_counter import m1_div_pkg::*; (
  input  wire  sys_clock_i,  // System clock
  input  wire  sys_reset_i,  // Sync reset, active high
  input  logic load_i,       // Preset to full step count
  input  logic step_i,       // One step taken
  output logic last_step_o   // Current step is the final one
);

  logic [step_cnt_width_lp-1:0] count_q;  // Steps still to go

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= step_cnt_width_lp'(div_steps_lp);
    end else if (step_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign last_step_o = (count_q == step_cnt_width_lp'(1));  // Only one left

  // FSM must stop stepping before the count runs out
  assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    step_i |-> (count_q != '0))
    else $error("step_i with zero step count");

endmodule

`default_nettype wire

// File: source/m1_div_operand_prep.sv
/* Captures the request operands at load and turns them into magnitudes.
   Also records whether quotient and remainder need a final sign flip. */
`timescale 1ns/10ps
`default_nettype none

module m1_div_operand_prep import m1_div_pkg::*; (
  input  wire             sys_clock_i,  // System clock
  input  wire             sys_reset_i,  // Sync reset, active high
  input  logic            load_i,       // Capture strobe
  input  div_operands_t   operands_i,   // Raw request operands
  output div_magnitudes_t mags_o        // Registered magnitudes and sign
);

  logic            dividend_neg;  // Signed and top bit set
  logic            divisor_neg;
  div_magnitudes_t mags_d;        // Next capture value
  div_magnitudes_t mags_q;

  assign dividend_neg = operands_i.is_signed & operands_i.dividend[div_width_lp-1];
  assign divisor_neg  = operands_i.is_signed & operands_i.divisor[div_width_lp-1];

  // Two's-complement absolute value only where needed
  always_comb begin
    mags_d.dividend_mag = dividend_neg ? (~operands_i.dividend + 1'b1)
                                       : operands_i.dividend;
    mags_d.divisor_mag  = divisor_neg  ? (~operands_i.divisor + 1'b1)
                                       : operands_i.divisor;
    // Exactly one negative operand flips both results
    mags_d.negate = operands_i.is_signed &
                    (operands_i.dividend[div_width_lp-1] ^
                     operands_i.divisor[div_width_lp-1]);
  end

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      mags_q <= '0;
    end else if (load_i) begin
      mags_q <= mags_d;  // Held for the whole run
    end
  end

  assign mags_o = mags_q;

endmodule

`default_nettype wire

// File: source/m1_div_datapath.sv
/* Restoring shift-subtract divider core, one quotient bit per step.
   Applies the sign correction on finish and holds the results until the next one. */
`timescale 1ns/10ps
`default_nettype none

module m1_div_datapath import m1_div_pkg::*; (
  input  wire             sys_clock_i,  // System clock
  input  wire             sys_reset_i,  // Sync reset, active high
  input  logic            step_i,       // One iteration
  input  logic            finish_i,     // Register final results
  input  div_magnitudes_t mags_i,       // Stable operand magnitudes
  output div_results_t    results_o     // Completed quotient and remainder
);

  localparam int wide_lp = 2 * div_width_lp;  // Partial remainder width

  logic                    first_q;   // Next step starts a new division
  logic [wide_lp-1:0]      rem_q;     // Partial remainder
  logic [wide_lp-1:0]      dvs_q;     // Shifted divisor
  logic [div_width_lp-1:0] quo_q;     // Quotient bits so far
  logic [wide_lp-1:0]      rem_cur;   // Step inputs, seeded on first step
  logic [wide_lp-1:0]      dvs_cur;
  logic [div_width_lp-1:0] quo_cur;
  logic [wide_lp-1:0]      diff;      // Trial subtraction
  div_results_t            results_q;

  // Seed from the magnitudes on the first step
  always_comb begin
    if (first_q) begin
      rem_cur = {{div_width_lp{1'b0}}, mags_i.dividend_mag};
      dvs_cur = {1'b0, mags_i.divisor_mag, {(div_width_lp-1){1'b0}}};  // Divisor << 31
      quo_cur = '0;
    end else begin
      rem_cur = rem_q;
      dvs_cur = dvs_q;
      quo_cur = quo_q;
    end
  end

  assign diff = rem_cur - dvs_cur;

  // First-step flag, re-armed after each finish
  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      first_q <= 1'b1;
    end else if (finish_i) begin
      first_q <= 1'b1;
    end else if (step_i) begin
      first_q <= 1'b0;
    end
  end

  // Iteration registers
  always_ff @(posedge sys_clock_i) begin
    if (step_i) begin
      quo_q <= {quo_cur[div_width_lp-2:0], ~diff[wide_lp-1]};  // 1 when it fits
      rem_q <= diff[wide_lp-1] ? rem_cur : diff;              // Restore on borrow
      dvs_q <= dvs_cur >> 1;
    end
  end

  // Sign fix and result capture
  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      results_q <= '0;
    end else if (finish_i) begin
      results_q.quotient  <= mags_i.negate ? (~quo_q + 1'b1) : quo_q;
      results_q.remainder <= mags_i.negate ? (~rem_q[div_width_lp-1:0] + 1'b1)
                                           : rem_q[div_width_lp-1:0];
    end
  end

  assign results_o = results_q;

endmodule

`default_nettype wire

// File: source/m1_div.sv
/* Top of the M1 32-bit integer divider with ABP handshake.
   Toggle abp_req_i with operands held; results are valid once abp_ack_o matches. */
`timescale 1ns/10ps
`default_nettype none

module m1_div import m1_div_pkg::*; (
  input  wire           sys_clock_i,    // System clock
  input  wire           sys_reset_i,    // Sync reset, active high
  input  div_operands_t operands_i,     // Dividend, divisor, signedness
  input  logic          abp_req_i,      // ABP request level
  output logic          abp_ack_o,      // ABP acknowledge level
  output div_results_t  div_results_o   // Quotient and remainder
);

  logic            load;       // FSM to prep and counter
  logic            step;       // FSM to datapath and counter
  logic            finish;     // FSM to datapath
  logic            last_step;  // Counter to FSM
  div_magnitudes_t mags;       // Prep to datapath

  m1_div_ctrl u_ctrl (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .abp_req_i   (abp_req_i),
    .last_step_i (last_step),
    .load_o      (load),
    .step_o      (step),
    .finish_o    (finish),
    .abp_ack_o   (abp_ack_o)
  );

  m1_div_step_counter u_step_counter (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .load_i      (load),
    .step_i      (step),
    .last_step_o (last_step)
  );

  m1_div_operand_prep u_operand_prep (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .load_i      (load),
    .operands_i  (operands_i),
    .mags_o      (mags)
  );

  m1_div_datapath u_datapath (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .step_i      (step),
    .finish_i    (finish),
    .mags_i      (mags),
    .results_o   (div_results_o)
  );

endmodule

`default_nettype wire

// File: verif/m1_div_tb.sv
/* Directed testbench for the M1 divider: drives ABP requests into the DUT and
   checks results and latency against a behavioural division model. */
`timescale 1ns/10ps
`default_nettype none

module m1_div_tb import m1_div_pkg::*; ();

  localparam int num_ops_lp      = 213;                 // Divisions issued by all tests
  localparam int limit_cycles_lp = num_ops_lp * 40 + 100;
  localparam int latency_lp      = 34;                  // E0 to ack

  logic          sys_clock_i;
  logic          sys_reset_i;
  div_operands_t operands_i;
  logic          abp_req_i;
  logic          abp_ack_o;
  div_results_t  div_results_o;

  int errors;       // Failed checks overall
  int pass_tests;
  int fail_tests;

  m1_div uut (
    .sys_clock_i   (sys_clock_i),
    .sys_reset_i   (sys_reset_i),
    .operands_i    (operands_i),
    .abp_req_i     (abp_req_i),
    .abp_ack_o     (abp_ack_o),
    .div_results_o (div_results_o)
  );

  initial begin
    sys_clock_i = 1'b0;
    forever #2 sys_clock_i = ~sys_clock_i;  // 4 ns period
  end

  // Magnitude division, zero divisor rule, then joint sign flip
  function automatic div_results_t model_div(input div_operands_t op);
    logic [div_width_lp-1:0] a;
    logic [div_width_lp-1:0] b;
    logic [div_width_lp-1:0] q;
    logic [div_width_lp-1:0] r;
    div_results_t            res;
    a = (op.is_signed && op.dividend[div_width_lp-1]) ? (0 - op.dividend) : op.dividend;
    b = (op.is_signed && op.divisor[div_width_lp-1]) ? (0 - op.divisor) : op.divisor;
    if (b == 0) begin
      q = '1;  // All ones on zero divisor
      r = a;
    end else begin
      q = a / b;
      r = a % b;
    end
    if (op.is_signed && (op.dividend[div_width_lp-1] ^ op.divisor[div_width_lp-1])) begin
      q = 0 - q;
      r = 0 - r;  // Remainder follows quotient sign
    end
    res.quotient  = q;
    res.remainder = r;
    return res;
  endfunction

  task automatic compare_results(input string name, input div_results_t exp,
                                 input div_results_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic compare_latency(input string name, input integer exp, input integer act);
    if (act !== exp) begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
    end
  endtask

  task automatic compare_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    if (errors == errors_at_start) begin
      pass_tests++;
      $display("Test %s: ok", name);
    end else begin
      fail_tests++;
      $display("Test %s: failed", name);
    end
  endtask

  // Called 1 ns after an edge; returns 1 ns after the ack edge
  task automatic run_division(input div_operands_t op, output div_results_t got);
    div_results_t held;
    logic         req_next;
    integer       cycles;
    bit           done;
    held       = div_results_o;  // Must not move until completion
    req_next   = ~abp_req_i;
    operands_i = op;
    abp_req_i  = req_next;       // Toggle request level
    cycles     = 0;
    done       = 0;
    @(posedge sys_clock_i);      // E0
    while (!done && cycles < 2 * latency_lp) begin
      @(posedge sys_clock_i);
      #1;
      cycles++;
      if (abp_ack_o === req_next) done = 1;
      else compare_results("div_results_o (held)", held, div_results_o);
    end
    got = div_results_o;
    if (!done) begin
      errors++;
      $display("Error at %0t: no acknowledge for the request within %0d cycles",
               $time, 2 * latency_lp);
    end else begin
      compare_results("div_results_o", model_div(op), got);
      compare_latency("ack latency", latency_lp, cycles);
    end
  endtask

  task automatic divide(input logic [31:0] a, input logic [31:0] b, input logic sgn);
    div_operands_t op;
    div_results_t  got;
    op.dividend  = a;
    op.divisor   = b;
    op.is_signed = sgn;
    run_division(op, got);
  endtask

  task automatic test_reset_and_basic();
    int           e0;
    div_results_t exp_r;
    div_results_t got;
    div_operands_t op;
    e0 = errors;
    compare_level("abp_ack_o", 1'b0, abp_ack_o);
    compare_results("div_results_o", '0, div_results_o);  // Cleared by reset
    op.dividend  = 32'd100;
    op.divisor   = 32'd7;
    op.is_signed = 1'b0;
    run_division(op, got);
    exp_r.quotient  = 32'd14;
    exp_r.remainder = 32'd2;
    compare_results("div_results_o", exp_r, got);
    report_test("reset and 100/7", e0);
  endtask

  task automatic test_unsigned_top_bit();
    int e0;
    e0 = errors;
    divide(32'hf000_0000, 32'h8000_0001, 1'b0);
    divide(32'h8000_0000, 32'hffff_ffff, 1'b0);  // Dividend below divisor
    divide(32'hffff_ffff, 32'h0000_0003, 1'b0);
    divide(32'hdead_beef, 32'h0001_0000, 1'b0);
    report_test("unsigned top bit", e0);
  endtask

  task automatic test_signed_combos();
    int e0;
    e0 = errors;
    divide(-32'sd100, 32'sd7, 1'b1);
    divide(32'sd100, -32'sd7, 1'b1);
    divide(-32'sd100, -32'sd7, 1'b1);
    divide(32'sd100, 32'sd7, 1'b1);
    divide(32'h8000_0000, 32'hffff_ffff, 1'b1);  // Most negative by -1
    report_test("signed combinations", e0);
  endtask

  task automatic test_divide_by_zero();
    int e0;
    e0 = errors;
    divide(32'd1234, 32'd0, 1'b0);
    divide(-32'sd1234, 32'd0, 1'b1);  // Negative dividend flips both
    divide(32'd1234, 32'd0, 1'b1);
    report_test("divide by zero", e0);
  endtask

  task automatic test_random_back_to_back();
    int           e0;
    logic [31:0]  a;
    logic [31:0]  b;
    e0 = errors;
    repeat (200) begin
      a = $urandom;
      b = ($urandom % 4 == 0) ? ($urandom & 32'hff) : $urandom;  // Some small divisors
      divide(a, b, $urandom % 2);
    end
    report_test("random back-to-back", e0);
  endtask

  // Ends a hung run
  initial begin
    repeat (limit_cycles_lp) @(posedge sys_clock_i);
    $display("Watchdog expired after %0d cycles", limit_cycles_lp);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    errors      = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    sys_reset_i = 1'b1;
    abp_req_i   = 1'b0;
    operands_i  = '0;
    void'($urandom(32'hb63b_ed3c));   // One seed per run
    repeat (2) @(posedge sys_clock_i);
    #1;
    sys_reset_i = 1'b0;
    test_reset_and_basic();
    test_unsigned_top_bit();
    test_signed_combos();
    test_divide_by_zero();
    test_random_back_to_back();
    $display("Tests passed %0d failed %0d", pass_tests, fail_tests);
    if (errors == 0 && fail_tests == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
source/m1_div_pkg.sv
source/m1_div_ctrl.sv
source/m1_div_step_counter.sv
source/m1_div_operand_prep.sv
source/m1_div_datapath.sv
source/m1_div.sv
verif/m1_div_tb.sv

// File: Bender.yml
package:
  name: m1_div

sources:
  - source/m1_div_pkg.sv
  - source/m1_div_ctrl.sv
  - source/m1_div_step_counter.sv
  - source/m1_div_operand_prep.sv
  - source/m1_div_datapath.sv
  - source/m1_div.sv
  - target: test
    files:
      - verif/m1_div_tb.sv
